//--- bp_pkg.sv
// --------------------------------------------------
// branch predictor shared definitions
// fetch block geometry, counter type, address views
// --------------------------------------------------

package bp_pkg;

  // ----------------------------------------------
  // address and fetch block geometry
  // ----------------------------------------------
  localparam int VADDR_W = 32;
  typedef logic [VADDR_W-1:0] vaddr_t;

  // four 4-byte lanes per 16-byte block
  localparam int LANES  = 4;
  localparam int LANE_W = 2;

  // ----------------------------------------------
  // gshare history and tables
  // ----------------------------------------------
  localparam int GHIST_W = 8;
  typedef logic [GHIST_W-1:0] ghist_t;

  // 2-bit counter, msb set means taken
  typedef logic [1:0] bim_t;
  localparam bim_t BIM_INIT = 2'b10;

  // ----------------------------------------------
  // btb geometry
  // ----------------------------------------------
  localparam int BTB_IDX_W = 4;
  localparam int BTB_TAG_W = VADDR_W - BTB_IDX_W - LANE_W - 2;

  // one fetch address seen by the btb and by gshare
  typedef union packed {
    struct packed {
      logic [BTB_TAG_W-1:0] tag;
      logic [BTB_IDX_W-1:0] idx;
      logic [LANE_W-1:0]    lane;
      logic [1:0]           byte_off;
    } btb;
    struct packed {
      logic [VADDR_W-GHIST_W-LANE_W-3:0] upper;
      ghist_t                            hist;
      logic [LANE_W-1:0]                 lane;
      logic [1:0]                        byte_off;
    } gs;
  } fetch_pc_u;

endpackage

//--- bp_update_stage.sv
// --------------------------------------------------
// commit update stage
// filters dead updates, computes the new counter
// --------------------------------------------------

`timescale 1ns/1ps

module bp_update_stage
  import bp_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,

  input  logic              i_upd_valid,
  input  logic              i_upd_dead,
  input  vaddr_t            i_upd_pc,
  input  logic              i_upd_taken,
  input  logic              i_upd_mispredict,
  input  logic              i_upd_is_cond,
  input  vaddr_t            i_upd_target,
  input  bim_t              i_upd_bim_value,
  input  ghist_t            i_upd_gshare_index,
  input  ghist_t            i_upd_bhr,

  output logic              o_wr_valid,
  output logic [LANE_W-1:0] o_wr_lane,
  output ghist_t            o_wr_index,
  output bim_t              o_wr_bim,
  output vaddr_t            o_wr_pc,
  output logic              o_wr_taken,
  output logic              o_wr_is_cond,
  output vaddr_t            o_wr_target,
  output logic              o_wr_repair,
  output ghist_t            o_wr_repair_bhr
);

  fetch_pc_u w_upd_pc;
  logic      w_live;
  bim_t      w_next_bim;

  assign w_upd_pc = i_upd_pc;
  assign w_live   = i_upd_valid & ~i_upd_dead;

  // saturated counter that agrees with the outcome holds
  always_comb begin
    if (i_upd_taken && (i_upd_bim_value == 2'b11)) begin
      w_next_bim = i_upd_bim_value;
    end else if (!i_upd_taken && (i_upd_bim_value == 2'b00)) begin
      w_next_bim = i_upd_bim_value;
    end else if (i_upd_taken) begin
      w_next_bim = bim_t'(i_upd_bim_value + 2'b01);
    end else begin
      w_next_bim = bim_t'(i_upd_bim_value - 2'b01);
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_wr_valid  <= 1'b0;
      o_wr_repair <= 1'b0;
    end else begin
      o_wr_valid  <= w_live;
      o_wr_repair <= w_live & i_upd_mispredict;
    end
  end

  // payload, only looked at while o_wr_valid is high
  always_ff @(posedge i_clk) begin
    o_wr_lane       <= w_upd_pc.btb.lane;
    o_wr_index      <= i_upd_gshare_index;
    o_wr_bim        <= w_next_bim;
    o_wr_pc         <= i_upd_pc;
    o_wr_taken      <= i_upd_taken;
    o_wr_is_cond    <= i_upd_is_cond;
    o_wr_target     <= i_upd_target;
    // history as it should have been after this branch
    o_wr_repair_bhr <= {i_upd_bhr[GHIST_W-2:0], i_upd_taken};
  end

endmodule

//--- bp_btb.sv
// --------------------------------------------------
// branch target buffer
// direct mapped, one entry per set and lane
// --------------------------------------------------

`timescale 1ns/1ps

module bp_btb
  import bp_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,

  input  logic               i_s0_valid,
  input  vaddr_t             i_s0_pc,

  input  logic               i_wr_valid,
  input  logic [LANE_W-1:0]  i_wr_lane,
  input  vaddr_t             i_wr_pc,
  input  logic               i_wr_taken,
  input  logic               i_wr_is_cond,
  input  vaddr_t             i_wr_target,

  output logic [LANES-1:0]   o_s1_hit,
  output logic [LANES-1:0]   o_s1_is_cond,
  output logic [LANES-1:0]   o_s2_hit,
  output vaddr_t [LANES-1:0] o_s2_target
);

  localparam int SETS = 2 ** BTB_IDX_W;

  fetch_pc_u w_s0_pc;
  fetch_pc_u w_wr_pc;

  logic                 r_s1_valid;
  logic [BTB_TAG_W-1:0] r_s1_tag;
  vaddr_t [LANES-1:0]   w_s1_target;

  assign w_s0_pc = i_s0_pc;
  assign w_wr_pc = i_wr_pc;

  // ----------------------------------------------
  // s0 -> s1 search pipe
  // ----------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
    end else begin
      r_s1_valid <= i_s0_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_tag <= w_s0_pc.btb.tag;
  end

  // ----------------------------------------------
  // per-lane entry arrays
  // ----------------------------------------------
  for (genvar l = 0; l < LANES; l++) begin : g_lane
    logic [SETS-1:0]      r_valid;
    logic [SETS-1:0]      r_cond;
    logic [BTB_TAG_W-1:0] r_tag [SETS];
    vaddr_t               r_target [SETS];
    logic                 w_wr_hit;

    logic                 r_s1_ent_valid;
    logic                 r_s1_ent_cond;
    logic [BTB_TAG_W-1:0] r_s1_ent_tag;
    vaddr_t               r_s1_ent_target;

    // only taken branches get installed
    assign w_wr_hit = i_wr_valid & i_wr_taken & (i_wr_lane == LANE_W'(l));

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_valid        <= '0;
        r_s1_ent_valid <= 1'b0;
      end else begin
        if (w_wr_hit) begin
          r_valid[w_wr_pc.btb.idx] <= 1'b1;
        end
        r_s1_ent_valid <= r_valid[w_s0_pc.btb.idx];
      end
    end

    always_ff @(posedge i_clk) begin
      if (w_wr_hit) begin
        r_cond[w_wr_pc.btb.idx]   <= i_wr_is_cond;
        r_tag[w_wr_pc.btb.idx]    <= w_wr_pc.btb.tag;
        r_target[w_wr_pc.btb.idx] <= i_wr_target;
      end
      r_s1_ent_cond   <= r_cond[w_s0_pc.btb.idx];
      r_s1_ent_tag    <= r_tag[w_s0_pc.btb.idx];
      r_s1_ent_target <= r_target[w_s0_pc.btb.idx];
    end

    // tag compare in s1
    assign o_s1_hit[l]     = r_s1_valid & r_s1_ent_valid & (r_s1_ent_tag == r_s1_tag);
    assign o_s1_is_cond[l] = r_s1_ent_cond;
    assign w_s1_target[l]  = r_s1_ent_target;
  end

  // ----------------------------------------------
  // s1 -> s2
  // ----------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_s2_hit <= '0;
    end else begin
      o_s2_hit <= o_s1_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    o_s2_target <= w_s1_target;
  end

endmodule

//--- bp_gshare.sv
// --------------------------------------------------
// gshare direction predictor
// history register, counter tables, taken-lane pick
// --------------------------------------------------

`timescale 1ns/1ps

module bp_gshare
  import bp_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,

  input  logic               i_s0_valid,
  input  vaddr_t             i_s0_pc,

  // from the btb
  input  logic [LANES-1:0]   i_s1_hit,
  input  logic [LANES-1:0]   i_s1_is_cond,
  input  logic [LANES-1:0]   i_s2_hit,
  input  vaddr_t [LANES-1:0] i_s2_target,

  // from the update stage
  input  logic               i_wr_valid,
  input  logic [LANE_W-1:0]  i_wr_lane,
  input  ghist_t             i_wr_index,
  input  bim_t               i_wr_bim,
  input  logic               i_wr_repair,
  input  ghist_t             i_wr_repair_bhr,

  output logic               o_s2_valid,
  output bim_t [LANES-1:0]   o_s2_bim_value,
  output ghist_t [LANES-1:0] o_s2_index,
  output ghist_t [LANES-1:0] o_s2_bhr,
  output logic [LANES-1:0]   o_s2_pred_taken,
  output logic               o_s2_predict_valid,
  output vaddr_t             o_s2_target
);

  localparam int ENTRIES = 2 ** GHIST_W;

  fetch_pc_u w_s0_pc;
  ghist_t    w_s0_index;

  ghist_t    r_bhr;
  logic      r_s1_valid;
  ghist_t    r_s1_index;

  bim_t [LANES-1:0] w_s1_bim;
  ghist_t           w_hist_chain [LANES+1];
  logic [LANES-1:0] w_s2_taken_oh;

  assign w_s0_pc    = i_s0_pc;
  assign w_s0_index = r_bhr ^ w_s0_pc.gs.hist;

  // ----------------------------------------------
  // history register
  // ----------------------------------------------
  // commit repair wins over a speculative shift
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_bhr <= '0;
    end else if (i_wr_repair) begin
      r_bhr <= i_wr_repair_bhr;
    end else if (r_s1_valid) begin
      r_bhr <= w_hist_chain[LANES];
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      o_s2_valid <= 1'b0;
    end else begin
      r_s1_valid <= i_s0_valid;
      o_s2_valid <= r_s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_index <= w_s0_index;
  end

  // s1 shift chain, lane 0 first
  assign w_hist_chain[0] = r_bhr;

  // ----------------------------------------------
  // per-lane counter tables
  // ----------------------------------------------
  for (genvar l = 0; l < LANES; l++) begin : g_lane
    bim_t               r_bim_tbl [ENTRIES];
    logic [ENTRIES-1:0] r_init_valid;
    logic               w_wr_lane;
    logic               w_bypass;
    bim_t               r_s1_bim;
    logic               r_s1_init;

    assign w_wr_lane = i_wr_valid & (i_wr_lane == LANE_W'(l));
    // write landing on the entry being read this cycle
    assign w_bypass  = w_wr_lane & (i_wr_index == w_s0_index);

    always_ff @(posedge i_clk) begin
      if (w_wr_lane) begin
        r_bim_tbl[i_wr_index] <= i_wr_bim;
      end
      r_s1_bim <= w_bypass ? i_wr_bim : r_bim_tbl[w_s0_index];
    end

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_init_valid <= '0;
        r_s1_init    <= 1'b0;
      end else begin
        if (w_wr_lane) begin
          r_init_valid[i_wr_index] <= 1'b1;
        end
        r_s1_init <= w_bypass | r_init_valid[w_s0_index];
      end
    end

    // never written entries read as weakly taken
    assign w_s1_bim[l] = r_s1_init ? r_s1_bim : BIM_INIT;

    assign w_hist_chain[l+1] = (i_s1_hit[l] & i_s1_is_cond[l]) ?
                               {w_hist_chain[l][GHIST_W-2:0], w_s1_bim[l][1]} :
                               w_hist_chain[l];
  end

  // ----------------------------------------------
  // s1 -> s2 results
  // ----------------------------------------------
  always_ff @(posedge i_clk) begin
    for (int l = 0; l < LANES; l++) begin
      o_s2_bim_value[l] <= w_s1_bim[l];
      o_s2_index[l]     <= r_s1_index;
      // history seen before this lane's own bit
      o_s2_bhr[l]       <= w_hist_chain[l];
    end
  end

  // ----------------------------------------------
  // s2 direction and target
  // ----------------------------------------------
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      o_s2_pred_taken[l] = o_s2_bim_value[l][1] & i_s2_hit[l];
    end
  end

  // isolate the lowest taken lane
  assign w_s2_taken_oh      = o_s2_pred_taken & (~o_s2_pred_taken + LANES'(1));
  assign o_s2_predict_valid = |o_s2_pred_taken;

  always_comb begin
    o_s2_target = '0;
    for (int l = 0; l < LANES; l++) begin
      o_s2_target = o_s2_target | ({VADDR_W{w_s2_taken_oh[l]}} & i_s2_target[l]);
    end
  end

endmodule

//--- bp_predictor_top.sv
// --------------------------------------------------
// branch predictor top
// update stage feeding the btb and gshare
// --------------------------------------------------

`timescale 1ns/1ps

module bp_predictor_top
  import bp_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,

  // search
  input  logic               i_s0_valid,
  input  vaddr_t             i_s0_pc,

  // commit
  input  logic               i_upd_valid,
  input  logic               i_upd_dead,
  input  vaddr_t             i_upd_pc,
  input  logic               i_upd_taken,
  input  logic               i_upd_mispredict,
  input  logic               i_upd_is_cond,
  input  vaddr_t             i_upd_target,
  input  bim_t               i_upd_bim_value,
  input  ghist_t             i_upd_gshare_index,
  input  ghist_t             i_upd_bhr,

  // s2 prediction
  output logic               o_s2_valid,
  output logic               o_s2_predict_valid,
  output vaddr_t             o_s2_target,
  output bim_t [LANES-1:0]   o_s2_bim_value,
  output ghist_t [LANES-1:0] o_s2_index,
  output ghist_t [LANES-1:0] o_s2_bhr,
  output logic [LANES-1:0]   o_s2_pred_taken
);

  logic               w_wr_valid;
  logic [LANE_W-1:0]  w_wr_lane;
  ghist_t             w_wr_index;
  bim_t               w_wr_bim;
  vaddr_t             w_wr_pc;
  logic               w_wr_taken;
  logic               w_wr_is_cond;
  vaddr_t             w_wr_target;
  logic               w_wr_repair;
  ghist_t             w_wr_repair_bhr;

  logic [LANES-1:0]   w_s1_hit;
  logic [LANES-1:0]   w_s1_is_cond;
  logic [LANES-1:0]   w_s2_hit;
  vaddr_t [LANES-1:0] w_s2_target;

  bp_update_stage u_update_stage (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_upd_valid        (i_upd_valid),
    .i_upd_dead         (i_upd_dead),
    .i_upd_pc           (i_upd_pc),
    .i_upd_taken        (i_upd_taken),
    .i_upd_mispredict   (i_upd_mispredict),
    .i_upd_is_cond      (i_upd_is_cond),
    .i_upd_target       (i_upd_target),
    .i_upd_bim_value    (i_upd_bim_value),
    .i_upd_gshare_index (i_upd_gshare_index),
    .i_upd_bhr          (i_upd_bhr),
    .o_wr_valid         (w_wr_valid),
    .o_wr_lane          (w_wr_lane),
    .o_wr_index         (w_wr_index),
    .o_wr_bim           (w_wr_bim),
    .o_wr_pc            (w_wr_pc),
    .o_wr_taken         (w_wr_taken),
    .o_wr_is_cond       (w_wr_is_cond),
    .o_wr_target        (w_wr_target),
    .o_wr_repair        (w_wr_repair),
    .o_wr_repair_bhr    (w_wr_repair_bhr)
  );

  bp_btb u_btb (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_s0_valid   (i_s0_valid),
    .i_s0_pc      (i_s0_pc),
    .i_wr_valid   (w_wr_valid),
    .i_wr_lane    (w_wr_lane),
    .i_wr_pc      (w_wr_pc),
    .i_wr_taken   (w_wr_taken),
    .i_wr_is_cond (w_wr_is_cond),
    .i_wr_target  (w_wr_target),
    .o_s1_hit     (w_s1_hit),
    .o_s1_is_cond (w_s1_is_cond),
    .o_s2_hit     (w_s2_hit),
    .o_s2_target  (w_s2_target)
  );

  bp_gshare u_gshare (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_s0_valid         (i_s0_valid),
    .i_s0_pc            (i_s0_pc),
    .i_s1_hit           (w_s1_hit),
    .i_s1_is_cond       (w_s1_is_cond),
    .i_s2_hit           (w_s2_hit),
    .i_s2_target        (w_s2_target),
    .i_wr_valid         (w_wr_valid),
    .i_wr_lane          (w_wr_lane),
    .i_wr_index         (w_wr_index),
    .i_wr_bim           (w_wr_bim),
    .i_wr_repair        (w_wr_repair),
    .i_wr_repair_bhr    (w_wr_repair_bhr),
    .o_s2_valid         (o_s2_valid),
    .o_s2_bim_value     (o_s2_bim_value),
    .o_s2_index         (o_s2_index),
    .o_s2_bhr           (o_s2_bhr),
    .o_s2_pred_taken    (o_s2_pred_taken),
    .o_s2_predict_valid (o_s2_predict_valid),
    .o_s2_target        (o_s2_target)
  );

endmodule

//--- bp_predictor_assertions.sv
// --------------------------------------------------
// gshare protocol checks, bound into bp_gshare
// --------------------------------------------------

`timescale 1ns/1ps

module bp_predictor_assertions
  import bp_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_s0_valid,
  input  logic             i_s2_valid,
  input  logic             i_predict_valid,
  input  logic [LANES-1:0] i_pred_taken,
  input  logic [LANES-1:0] i_s1_hit
);

  int fail_count = 0;

  // fixed two-cycle search latency
  a_s2_latency : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_s2_valid == $past(i_s0_valid, 2))
    else begin
      fail_count++;
      $error("s2 valid does not follow s0 valid by two cycles");
    end

  a_predict_needs_valid : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_predict_valid |-> i_s2_valid)
    else begin
      fail_count++;
      $error("prediction raised without a valid s2 result");
    end

  // a taken lane must have hit in the btb one stage earlier
  a_taken_subset_of_hit : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_pred_taken & ~$past(i_s1_hit)) == '0)
    else begin
      fail_count++;
      $error("taken lane without a btb hit");
    end

endmodule

bind bp_gshare bp_predictor_assertions u_assertions (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_s0_valid      (i_s0_valid),
  .i_s2_valid      (o_s2_valid),
  .i_predict_valid (o_s2_predict_valid),
  .i_pred_taken    (o_s2_pred_taken),
  .i_s1_hit        (i_s1_hit)
);

//--- tb_bp_predictor.sv
// --------------------------------------------------
// testbench for the branch predictor top
// table of searches and updates against a reference model
// --------------------------------------------------

`timescale 1ns/1ps

module tb_bp_predictor
  import bp_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int KIND_IDLE   = 0;
  localparam int KIND_SEARCH = 1;
  localparam int KIND_UPDATE = 2;
  localparam int SETS        = 2 ** BTB_IDX_W;
  localparam int ENTRIES     = 2 ** GHIST_W;

  localparam vaddr_t BLK_A = 32'h0001_2340;
  localparam vaddr_t BLK_B = 32'h0004_5670;
  localparam vaddr_t BLK_C = 32'h000A_BC00;

  typedef struct {
    int                 kind;
    vaddr_t             pc;
    logic               taken;
    logic               mispredict;
    logic               is_cond;
    logic               dead;
    vaddr_t             target;
    bim_t               bim;
    ghist_t             index;
    ghist_t             bhr_in;
    bim_t [LANES-1:0]   exp_bim;
    ghist_t             exp_index;
    ghist_t [LANES-1:0] exp_bhr;
    logic [LANES-1:0]   exp_pred;
    logic               exp_pv;
    vaddr_t             exp_target;
  } row_t;

  logic               i_clk;
  logic               i_reset_n;
  logic               i_s0_valid;
  vaddr_t             i_s0_pc;
  logic               i_upd_valid;
  logic               i_upd_dead;
  vaddr_t             i_upd_pc;
  logic               i_upd_taken;
  logic               i_upd_mispredict;
  logic               i_upd_is_cond;
  vaddr_t             i_upd_target;
  bim_t               i_upd_bim_value;
  ghist_t             i_upd_gshare_index;
  ghist_t             i_upd_bhr;
  logic               o_s2_valid;
  logic               o_s2_predict_valid;
  vaddr_t             o_s2_target;
  bim_t [LANES-1:0]   o_s2_bim_value;
  ghist_t [LANES-1:0] o_s2_index;
  ghist_t [LANES-1:0] o_s2_bhr;
  logic [LANES-1:0]   o_s2_pred_taken;

  // ----------------------------------------------
  // reference model state
  // ----------------------------------------------
  logic                 m_btb_valid [SETS][LANES];
  logic [BTB_TAG_W-1:0] m_btb_tag [SETS][LANES];
  logic                 m_btb_cond [SETS][LANES];
  vaddr_t               m_btb_target [SETS][LANES];
  bim_t                 m_cnt [LANES][ENTRIES];
  logic                 m_init [LANES][ENTRIES];
  ghist_t               m_bhr;

  row_t   rows[$];
  int     n_rows;
  int     mismatches;
  int     failures;
  int     assertion_failures;
  integer seed;

  bp_predictor_top bp_predictor_top_i (.*);

  initial begin
    i_clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // ----------------------------------------------
  // compare tasks
  // ----------------------------------------------
  task automatic check_vaddr(input string what, input vaddr_t got, input vaddr_t exp);
    if (got !== exp) begin
      $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_bim(input string what, input bim_t got, input bim_t exp);
    if (got !== exp) begin
      $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_ghist(input string what, input ghist_t got, input ghist_t exp);
    if (got !== exp) begin
      $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
      mismatches++;
    end
  endtask

  // ----------------------------------------------
  // table building with the reference model
  // ----------------------------------------------
  function automatic row_t new_row(input int kind, input vaddr_t pc);
    row_t r;
    r.kind       = kind;
    r.pc         = pc;
    r.taken      = 1'b0;
    r.mispredict = 1'b0;
    r.is_cond    = 1'b0;
    r.dead       = 1'b0;
    r.target     = '0;
    r.bim        = '0;
    r.index      = '0;
    r.bhr_in     = '0;
    r.exp_bim    = '0;
    r.exp_index  = '0;
    r.exp_bhr    = '0;
    r.exp_pred   = '0;
    r.exp_pv     = 1'b0;
    r.exp_target = '0;
    return r;
  endfunction

  // gshare index a search of this block would use now
  function automatic ghist_t cur_index(input vaddr_t pc);
    return m_bhr ^ pc[11:4];
  endfunction

  function automatic vaddr_t rand_block();
    vaddr_t pc;
    pc = $random(seed);
    return {pc[VADDR_W-1:4], 4'h0};
  endfunction

  task automatic queue_search(input vaddr_t pc);
    row_t   r;
    ghist_t h;
    int     set_idx;
    logic   hit;
    logic   found;
    r       = new_row(KIND_SEARCH, pc);
    set_idx = pc[7:4];
    h       = m_bhr;
    found   = 1'b0;
    r.exp_index = cur_index(pc);
    for (int l = 0; l < LANES; l++) begin
      hit = m_btb_valid[set_idx][l] && (m_btb_tag[set_idx][l] == pc[31:8]);
      r.exp_bim[l] = m_init[l][r.exp_index] ? m_cnt[l][r.exp_index] : BIM_INIT;
      r.exp_bhr[l] = h;
      // conditional hits push their direction into the history
      if (hit && m_btb_cond[set_idx][l]) begin
        h = {h[GHIST_W-2:0], r.exp_bim[l][1]};
      end
      r.exp_pred[l] = hit & r.exp_bim[l][1];
      if (r.exp_pred[l] && !found) begin
        r.exp_target = m_btb_target[set_idx][l];
        found        = 1'b1;
      end
    end
    r.exp_pv = |r.exp_pred;
    m_bhr    = h;
    rows.push_back(r);
  endtask

  task automatic add_update(input vaddr_t pc, input logic taken, input logic mispredict,
                            input logic is_cond, input vaddr_t target, input ghist_t index,
                            input ghist_t bhr_in, input logic dead);
    row_t r;
    int   lane;
    int   set_idx;
    bim_t nb;
    r            = new_row(KIND_UPDATE, pc);
    lane         = pc[3:2];
    set_idx      = pc[7:4];
    r.taken      = taken;
    r.mispredict = mispredict;
    r.is_cond    = is_cond;
    r.dead       = dead;
    r.target     = target;
    r.index      = index;
    r.bhr_in     = bhr_in;
    // counter value the frontend saw at predict time
    r.bim = m_init[lane][index] ? m_cnt[lane][index] : BIM_INIT;
    if (!dead) begin
      if (taken) begin
        nb = (r.bim == 2'b11) ? r.bim : r.bim + 2'b01;
      end else begin
        nb = (r.bim == 2'b00) ? r.bim : r.bim - 2'b01;
      end
      m_cnt[lane][index]  = nb;
      m_init[lane][index] = 1'b1;
      if (taken) begin
        m_btb_valid[set_idx][lane]  = 1'b1;
        m_btb_tag[set_idx][lane]    = pc[31:8];
        m_btb_cond[set_idx][lane]   = is_cond;
        m_btb_target[set_idx][lane] = target;
      end
      if (mispredict) begin
        m_bhr = {bhr_in[GHIST_W-2:0], taken};
      end
    end
    rows.push_back(r);
  endtask

  task automatic pad_idle();
    rows.push_back(new_row(KIND_IDLE, '0));
  endtask

  task automatic build_table();
    ghist_t b_idx;
    // empty btb, no prediction anywhere
    queue_search(rand_block());
    queue_search(rand_block());
    pad_idle();
    // taken conditional branch in lane 1 of block A
    add_update(BLK_A + 4, 1'b1, 1'b0, 1'b1, 32'h0000_8000, cur_index(BLK_A), m_bhr, 1'b0);
    // back to back searches see the shifted history
    queue_search(BLK_A);
    queue_search(BLK_A);
    queue_search(BLK_A);
    // block B lane 2, then not-taken training after a repair
    add_update(BLK_B + 8, 1'b1, 1'b0, 1'b1, 32'h0000_9000, cur_index(BLK_B), m_bhr, 1'b0);
    b_idx = 8'hB4 ^ BLK_B[11:4];
    add_update(BLK_B + 8, 1'b0, 1'b1, 1'b1, '0, b_idx, 8'h5A, 1'b0);
    add_update(BLK_B + 8, 1'b0, 1'b0, 1'b1, '0, b_idx, m_bhr, 1'b0);
    add_update(BLK_B + 8, 1'b0, 1'b0, 1'b1, '0, b_idx, m_bhr, 1'b0);
    queue_search(BLK_B);
    // two unconditional taken lanes in block C
    add_update(BLK_C + 4, 1'b1, 1'b0, 1'b0, 32'h0000_A100, cur_index(BLK_C), m_bhr, 1'b0);
    add_update(BLK_C + 12, 1'b1, 1'b0, 1'b0, 32'h0000_A300, cur_index(BLK_C), m_bhr, 1'b0);
    queue_search(BLK_C);
    // dead update must leave everything alone
    add_update(BLK_C + 4, 1'b0, 1'b1, 1'b1, '0, cur_index(BLK_C), 8'hFF, 1'b1);
    queue_search(BLK_C);
    for (int i = 0; i < 6; i++) begin
      queue_search(rand_block());
    end
    pad_idle();
  endtask

  // ----------------------------------------------
  // driving and checking
  // ----------------------------------------------
  task automatic drive_row(input row_t r);
    i_s0_valid         <= (r.kind == KIND_SEARCH);
    i_s0_pc            <= r.pc;
    i_upd_valid        <= (r.kind == KIND_UPDATE);
    i_upd_dead         <= r.dead;
    i_upd_pc           <= r.pc;
    i_upd_taken        <= r.taken;
    i_upd_mispredict   <= r.mispredict;
    i_upd_is_cond      <= r.is_cond;
    i_upd_target       <= r.target;
    i_upd_bim_value    <= r.bim;
    i_upd_gshare_index <= r.index;
    i_upd_bhr          <= r.bhr_in;
  endtask

  task automatic await_result(input int n, input row_t r);
    logic seen;
    seen = 1'b0;
    for (int w = 0; w < 4 && !seen; w++) begin
      @(negedge i_clk);
      seen = o_s2_valid;
    end
    if (!seen) begin
      $display("ERROR @%0t: search in row %0d never produced an s2 result", $time, n);
      failures++;
    end else begin
      check_bit($sformatf("row %0d predict_valid", n), o_s2_predict_valid, r.exp_pv);
      check_vaddr($sformatf("row %0d target", n), o_s2_target, r.exp_target);
      for (int l = 0; l < LANES; l++) begin
        check_bim($sformatf("row %0d lane %0d bim", n, l), o_s2_bim_value[l], r.exp_bim[l]);
        check_ghist($sformatf("row %0d lane %0d index", n, l), o_s2_index[l], r.exp_index);
        check_ghist($sformatf("row %0d lane %0d bhr", n, l), o_s2_bhr[l], r.exp_bhr[l]);
        check_bit($sformatf("row %0d lane %0d taken", n, l), o_s2_pred_taken[l],
                  r.exp_pred[l]);
      end
    end
  endtask

  task automatic apply_row(input int n, input row_t r);
    @(posedge i_clk);
    drive_row(r);
    if (r.kind == KIND_SEARCH) begin
      @(posedge i_clk);
      drive_row(new_row(KIND_IDLE, '0));
      await_result(n, r);
    end else if (r.kind == KIND_UPDATE && (r.taken || r.mispredict)) begin
      // btb install and repair need a cycle before the next search
      @(posedge i_clk);
      drive_row(new_row(KIND_IDLE, '0));
    end
  endtask

  // ----------------------------------------------
  // main sequence and watchdog
  // ----------------------------------------------
  initial begin
    seed               = 86771;
    n_rows             = 0;
    mismatches         = 0;
    failures           = 0;
    assertion_failures = 0;
    m_bhr              = '0;
    i_reset_n          = 1'b0;
    drive_row(new_row(KIND_IDLE, '0));
    for (int s = 0; s < SETS; s++) begin
      for (int l = 0; l < LANES; l++) begin
        m_btb_valid[s][l] = 1'b0;
      end
    end
    for (int l = 0; l < LANES; l++) begin
      for (int e = 0; e < ENTRIES; e++) begin
        m_init[l][e] = 1'b0;
      end
    end
    build_table();
    n_rows = rows.size();
    repeat (8) @(posedge i_clk);
    i_reset_n <= 1'b1;
    for (int n = 0; n < n_rows; n++) begin
      apply_row(n, rows[n]);
    end
    @(posedge i_clk);
    assertion_failures = bp_predictor_top_i.u_gshare.u_assertions.fail_count;
    $display("rows %0d, mismatches %0d, other failures %0d, assertion failures %0d",
             n_rows, mismatches, failures, assertion_failures);
    if (mismatches == 0 && failures == 0 && assertion_failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    wait (n_rows != 0);
    #((n_rows * 4 + 8 + 20) * CLK_PERIOD);
    $display("ERROR: run did not finish within the time allowed for %0d rows", n_rows);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- gshare_frontend.f
bp_pkg.sv
bp_update_stage.sv
bp_btb.sv
bp_gshare.sv
bp_predictor_top.sv
bp_predictor_assertions.sv
tb_bp_predictor.sv
